/* include/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and register file sizing
`define XLEN        32
`define REG_INDEX_W 5
`define REG_COUNT   32

`define RESET_PC    32'h8000_0000

// rv32i major opcodes in use
`define OP_LUI      7'b0110111
`define OP_JAL      7'b1101111
`define OP_BRANCH   7'b1100011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_IMM      7'b0010011
`define OP_REG      7'b0110011

// mem_size codes on the data port
`define SIZE_BYTE   2'd0
`define SIZE_WORD   2'd2

`endif

/* src/core_pkg.sv */
`default_nettype none

`include "core_params.svh"

package core_pkg;

    typedef struct packed {
        logic [6:0]              funct7;
        logic [`REG_INDEX_W-1:0] rs2;
        logic [`REG_INDEX_W-1:0] rs1;
        logic [2:0]              funct3;
        logic [`REG_INDEX_W-1:0] rd;
        logic [6:0]              opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]             imm;
        logic [`REG_INDEX_W-1:0] rs1;
        logic [2:0]              funct3;
        logic [`REG_INDEX_W-1:0] rd;
        logic [6:0]              opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]              imm_hi;
        logic [`REG_INDEX_W-1:0] rs2;
        logic [`REG_INDEX_W-1:0] rs1;
        logic [2:0]              funct3;
        logic [4:0]              imm_lo;
        logic [6:0]              opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                    imm12;
        logic [5:0]              imm10_5;
        logic [`REG_INDEX_W-1:0] rs2;
        logic [`REG_INDEX_W-1:0] rs1;
        logic [2:0]              funct3;
        logic [3:0]              imm4_1;
        logic                    imm11;
        logic [6:0]              opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]             imm;
        logic [`REG_INDEX_W-1:0] rd;
        logic [6:0]              opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                    imm20;
        logic [9:0]              imm10_1;
        logic                    imm11;
        logic [7:0]              imm19_12;
        logic [`REG_INDEX_W-1:0] rd;
        logic [6:0]              opcode;
    } j_fmt_t;

    // one instruction word, seen through each format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE
    } cmp_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_LINK
    } wb_sel_e;

endpackage

`default_nettype wire

/* src/dec_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

interface dec_if;
    import core_pkg::*;

    logic [`REG_INDEX_W-1:0] rs1_index;
    logic [`REG_INDEX_W-1:0] rs2_index;
    logic [`REG_INDEX_W-1:0] rd_index;
    logic [`XLEN-1:0]        imm;
    alu_op_e                 alu_op;
    logic                    alu_src_pc;
    logic                    alu_src_imm;
    cmp_e                    cmp;
    wb_sel_e                 wb_sel;
    logic                    rd_write;
    logic                    byte_access;
    logic                    mem_write;

    modport ctrl (
        output rs1_index, rs2_index, rd_index, imm, alu_op, alu_src_pc, alu_src_imm,
        output cmp, wb_sel, rd_write, byte_access, mem_write
    );

    // operand b may be the immediate, so the alu sees imm as well
    modport alu (input alu_op, alu_src_pc, alu_src_imm, cmp, imm);
    modport rf  (input rs1_index, rs2_index, rd_index, wb_sel, rd_write);
    modport pc  (input imm);
    modport lsu (input byte_access, mem_write);

endinterface

`default_nettype wire

/* src/core_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module core_ctrl (
    input  wire              inst_selfdefine,
    input  wire              reset,
    input  wire              if_ready,
    input  wire [`XLEN-1:0]  if_data_read,
    input  wire              mem_ready,
    input  wire              cmp_true,
    output logic             if_valid,
    output logic             mem_start,
    output logic             pc_load,
    output logic             pc_take_target,
    dec_if.ctrl              dec
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_MEM
    } state_e;

    state_e     state;
    inst_u      ir;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       writes_rd;
    logic       is_mem;
    logic       is_jal;
    logic       is_branch;

    // funct3 to alu op, shared by op-imm and op-reg
    function automatic alu_op_e f3_op(input logic [2:0] f3);
        case (f3)
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state    <= S_FETCH;
            if_valid <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (if_valid && if_ready) begin
                        state    <= S_EXEC;
                        if_valid <= 1'b0;
                    end else begin
                        if_valid <= 1'b1;
                    end
                end
                S_EXEC: begin
                    state    <= is_mem ? S_MEM : S_FETCH;
                    if_valid <= !is_mem;
                end
                S_MEM: begin
                    if (mem_ready) begin
                        state    <= S_FETCH;
                        if_valid <= 1'b1;
                    end
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    // instruction register
    always_ff @(posedge inst_selfdefine) begin
        if (state == S_FETCH && if_valid && if_ready) begin
            ir <= if_data_read;
        end
    end

    assign opcode        = ir.r_fmt.opcode;
    assign funct3        = ir.r_fmt.funct3;
    assign dec.rs1_index = ir.r_fmt.rs1;
    assign dec.rs2_index = ir.r_fmt.rs2;
    assign dec.rd_index  = ir.r_fmt.rd;

    always_comb begin
        dec.imm         = '0;
        dec.alu_op      = ALU_ADD;
        dec.alu_src_pc  = 1'b0;
        dec.alu_src_imm = 1'b0;
        dec.cmp         = CMP_EQ;
        dec.wb_sel      = WB_ALU;
        dec.byte_access = 1'b0;
        dec.mem_write   = 1'b0;
        writes_rd       = 1'b0;
        is_mem          = 1'b0;
        is_jal          = 1'b0;
        is_branch       = 1'b0;
        case (opcode)
            `OP_LUI: begin
                dec.imm         = {ir.u_fmt.imm, 12'b0};
                dec.alu_op      = ALU_PASS_B;
                dec.alu_src_imm = 1'b1;
                writes_rd       = 1'b1;
            end
            `OP_JAL: begin
                dec.imm         = {{11{ir.j_fmt.imm20}}, ir.j_fmt.imm20, ir.j_fmt.imm19_12,
                                   ir.j_fmt.imm11, ir.j_fmt.imm10_1, 1'b0};
                dec.alu_src_pc  = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec.wb_sel      = WB_LINK;
                writes_rd       = 1'b1;
                is_jal          = 1'b1;
            end
            `OP_BRANCH: begin
                dec.imm   = {{19{ir.b_fmt.imm12}}, ir.b_fmt.imm12, ir.b_fmt.imm11,
                             ir.b_fmt.imm10_5, ir.b_fmt.imm4_1, 1'b0};
                is_branch = 1'b1;
                case (funct3)
                    3'b001:  dec.cmp = CMP_NE;
                    3'b100:  dec.cmp = CMP_LT;
                    3'b101:  dec.cmp = CMP_GE;
                    default: dec.cmp = CMP_EQ;
                endcase
            end
            `OP_LOAD: begin
                dec.imm         = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
                dec.alu_src_imm = 1'b1;
                dec.wb_sel      = WB_LOAD;
                dec.byte_access = (funct3 == 3'b100);
                writes_rd       = 1'b1;
                is_mem          = 1'b1;
            end
            `OP_STORE: begin
                dec.imm         = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
                dec.alu_src_imm = 1'b1;
                dec.byte_access = (funct3 == 3'b000);
                dec.mem_write   = 1'b1;
                is_mem          = 1'b1;
            end
            `OP_IMM: begin
                dec.imm         = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
                dec.alu_op      = f3_op(funct3);
                dec.alu_src_imm = 1'b1;
                writes_rd       = 1'b1;
            end
            `OP_REG: begin
                dec.alu_op = f3_op(funct3);
                if (funct3 == 3'b000 && ir.r_fmt.funct7[5]) begin
                    dec.alu_op = ALU_SUB;
                end
                writes_rd = 1'b1;
            end
            default: ;
        endcase
    end

    assign mem_start = (state == S_MEM);

    // retire at end of exec, or when the data port completes
    assign pc_load        = ((state == S_EXEC) && !is_mem) || (mem_start && mem_ready);
    assign pc_take_target = is_jal || (is_branch && cmp_true);
    assign dec.rd_write   = pc_load && writes_rd;

endmodule

`default_nettype wire

/* src/pc_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module pc_unit (
    input  wire              inst_selfdefine,
    input  wire              reset,
    input  wire              pc_load,
    input  wire              pc_take_target,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] link_addr,
    dec_if.pc                dec
);

    logic [`XLEN-1:0] target;

    assign link_addr = pc + `XLEN'd4;
    // branch and jal offsets are both pc relative
    assign target    = pc + dec.imm;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (pc_load) begin
            pc <= pc_take_target ? target : link_addr;
        end
    end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module reg_file (
    input  wire              inst_selfdefine,
    input  wire              reset,
    input  wire [`XLEN-1:0]  alu_result,
    input  wire [`XLEN-1:0]  load_data,
    input  wire [`XLEN-1:0]  link_addr,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data,
    dec_if.rf                dec
);
    import core_pkg::*;

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic [`XLEN-1:0] wr_data;

    always_comb begin
        case (dec.wb_sel)
            WB_LOAD: wr_data = load_data;
            WB_LINK: wr_data = link_addr;
            default: wr_data = alu_result;
        endcase
    end

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (dec.rd_write && dec.rd_index != '0) begin
            regs[dec.rd_index] <= wr_data;
        end
    end

    assign rs1_data = regs[dec.rs1_index];
    assign rs2_data = regs[dec.rs2_index];

endmodule

`default_nettype wire

/* src/alu_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module alu_unit (
    input  wire [`XLEN-1:0]  pc,
    input  wire [`XLEN-1:0]  rs1_data,
    input  wire [`XLEN-1:0]  rs2_data,
    output logic [`XLEN-1:0] alu_result,
    output logic             cmp_true,
    dec_if.alu               dec
);
    import core_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;

    assign op_a = dec.alu_src_pc ? pc : rs1_data;
    assign op_b = dec.alu_src_imm ? dec.imm : rs2_data;

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            // lui
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    // branch compare always works on the two registers
    always_comb begin
        case (dec.cmp)
            CMP_NE:  cmp_true = (rs1_data != rs2_data);
            CMP_LT:  cmp_true = ($signed(rs1_data) < $signed(rs2_data));
            CMP_GE:  cmp_true = ($signed(rs1_data) >= $signed(rs2_data));
            default: cmp_true = (rs1_data == rs2_data);
        endcase
    end

endmodule

`default_nettype wire

/* src/lsu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module lsu (
    input  wire              mem_start,
    input  wire [`XLEN-1:0]  alu_result,
    input  wire [`XLEN-1:0]  rs2_data,
    input  wire [`XLEN-1:0]  mem_data_read,
    output logic             mem_valid,
    output logic [`XLEN-1:0] mem_addr,
    output logic [`XLEN-1:0] mem_data_write,
    output logic [1:0]       mem_size,
    output logic             mem_req,
    output logic [`XLEN-1:0] load_data,
    dec_if.lsu               dec
);

    // request fields stay stable for the whole mem state
    assign mem_valid      = mem_start;
    assign mem_addr       = alu_result;
    assign mem_data_write = rs2_data;
    assign mem_size       = dec.byte_access ? `SIZE_BYTE : `SIZE_WORD;
    assign mem_req        = dec.mem_write;

    // lbu, the byte comes back in bits 7:0
    assign load_data = dec.byte_access ? {{(`XLEN-8){1'b0}}, mem_data_read[7:0]}
                                       : mem_data_read;

endmodule

`default_nettype wire

/* src/core_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module core_top (
    input  wire              inst_selfdefine,
    input  wire              reset,
    input  wire              if_ready,
    input  wire [`XLEN-1:0]  if_data_read,
    output wire              if_valid,
    output wire [`XLEN-1:0]  if_addr,
    output wire              mem_valid,
    input  wire              mem_ready,
    input  wire [`XLEN-1:0]  mem_data_read,
    output wire [`XLEN-1:0]  mem_addr,
    output wire [`XLEN-1:0]  mem_data_write,
    output wire [1:0]        mem_size,
    output wire              mem_req
);

    wire [`XLEN-1:0] link_addr;
    wire [`XLEN-1:0] rs1_data;
    wire [`XLEN-1:0] rs2_data;
    wire [`XLEN-1:0] alu_result;
    wire [`XLEN-1:0] load_data;
    wire             cmp_true;
    wire             mem_start;
    wire             pc_load;
    wire             pc_take_target;

    dec_if dec0 ();

    core_ctrl ctrl0 (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .if_ready        (if_ready),
        .if_data_read    (if_data_read),
        .mem_ready       (mem_ready),
        .cmp_true        (cmp_true),
        .if_valid        (if_valid),
        .mem_start       (mem_start),
        .pc_load         (pc_load),
        .pc_take_target  (pc_take_target),
        .dec             (dec0.ctrl)
    );

    // the pc is the fetch address
    pc_unit pcu0 (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .pc_load         (pc_load),
        .pc_take_target  (pc_take_target),
        .pc              (if_addr),
        .link_addr       (link_addr),
        .dec             (dec0.pc)
    );

    reg_file rf0 (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .alu_result      (alu_result),
        .load_data       (load_data),
        .link_addr       (link_addr),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .dec             (dec0.rf)
    );

    alu_unit alu0 (
        .pc              (if_addr),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .alu_result      (alu_result),
        .cmp_true        (cmp_true),
        .dec             (dec0.alu)
    );

    lsu lsu0 (
        .mem_start       (mem_start),
        .alu_result      (alu_result),
        .rs2_data        (rs2_data),
        .mem_data_read   (mem_data_read),
        .mem_valid       (mem_valid),
        .mem_addr        (mem_addr),
        .mem_data_write  (mem_data_write),
        .mem_size        (mem_size),
        .mem_req         (mem_req),
        .load_data       (load_data),
        .dec             (dec0.lsu)
    );

endmodule

`default_nettype wire

/* tb/core_props.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module core_props (
    input wire             inst_selfdefine,
    input wire             reset,
    input wire             if_valid,
    input wire             if_ready,
    input wire [`XLEN-1:0] if_addr,
    input wire             mem_valid,
    input wire             mem_ready,
    input wire [`XLEN-1:0] mem_addr,
    input wire [`XLEN-1:0] mem_data_write,
    input wire [1:0]       mem_size,
    input wire             mem_req
);

    int fail_count = 0;

    // fetch request held under back-pressure
    assert property (@(posedge inst_selfdefine) disable iff (reset)
        if_valid && !if_ready |=> if_valid && $stable(if_addr))
    else begin
        fail_count++;
        $error("fetch request changed before if_ready");
    end

    assert property (@(posedge inst_selfdefine) disable iff (reset)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr)
            && $stable(mem_data_write) && $stable(mem_size) && $stable(mem_req))
    else begin
        fail_count++;
        $error("data request changed before mem_ready");
    end

    // valid drops in the cycle after the completing one
    assert property (@(posedge inst_selfdefine) disable iff (reset)
        if_valid && if_ready |=> !if_valid)
    else begin
        fail_count++;
        $error("if_valid still high after a completed fetch");
    end

    assert property (@(posedge inst_selfdefine) disable iff (reset)
        mem_valid && mem_ready |=> !mem_valid)
    else begin
        fail_count++;
        $error("mem_valid still high after a completed transfer");
    end

    assert property (@(posedge inst_selfdefine) disable iff (reset)
        !(if_valid && mem_valid))
    else begin
        fail_count++;
        $error("fetch and data requests active together");
    end

endmodule

bind core_top core_props props0 (
    .inst_selfdefine (inst_selfdefine),
    .reset           (reset),
    .if_valid        (if_valid),
    .if_ready        (if_ready),
    .if_addr         (if_addr),
    .mem_valid       (mem_valid),
    .mem_ready       (mem_ready),
    .mem_addr        (mem_addr),
    .mem_data_write  (mem_data_write),
    .mem_size        (mem_size),
    .mem_req         (mem_req)
);

`default_nettype wire

/* tb/core_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module core_checker (
    input wire              inst_selfdefine,
    input wire              reset,
    input wire              if_valid,
    input wire              if_ready,
    input wire [`XLEN-1:0]  if_data_read,
    input wire [`XLEN-1:0]  if_addr,
    input wire              mem_valid,
    input wire              mem_ready,
    input wire [`XLEN-1:0]  mem_data_read,
    input wire [`XLEN-1:0]  mem_addr,
    input wire [`XLEN-1:0]  mem_data_write,
    input wire [1:0]        mem_size,
    input wire              mem_req,
    output wire [31:0]      error_count
);
    import core_pkg::*;

    logic [`XLEN-1:0]        regs_m [`REG_COUNT];
    logic [`XLEN-1:0]        pc_m;
    logic                    pending;
    logic                    pend_store;
    logic                    pend_byte;
    logic [`REG_INDEX_W-1:0] pend_rd;
    logic [`XLEN-1:0]        pend_addr;
    logic [`XLEN-1:0]        pend_data;
    int                      errors = 0;

    assign error_count = errors;

    function automatic logic [`XLEN-1:0] alu_model(input logic [2:0] f3, input logic sub,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [`XLEN-1:0] a,
                                          input logic [`XLEN-1:0] b);
        case (f3)
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            default: return a == b;
        endcase
    endfunction

    task automatic flag_mismatch(input string what, input logic [`XLEN-1:0] got,
                                 input logic [`XLEN-1:0] exp);
        errors++;
        $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
    endtask

    // x0 stays zero
    task automatic set_reg(input logic [`REG_INDEX_W-1:0] rd, input logic [`XLEN-1:0] v);
        if (rd != '0) begin
            regs_m[rd] = v;
        end
    endtask

    task automatic step_model(input inst_u ir);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm_i;
        logic [`XLEN-1:0] imm_s;
        logic [`XLEN-1:0] imm_b;
        logic [`XLEN-1:0] imm_j;
        a     = regs_m[ir.r_fmt.rs1];
        b     = regs_m[ir.r_fmt.rs2];
        imm_i = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
        imm_s = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
        imm_b = {{20{ir.b_fmt.imm12}}, ir.b_fmt.imm11, ir.b_fmt.imm10_5,
                 ir.b_fmt.imm4_1, 1'b0};
        imm_j = {{12{ir.j_fmt.imm20}}, ir.j_fmt.imm19_12, ir.j_fmt.imm11,
                 ir.j_fmt.imm10_1, 1'b0};
        case (ir.r_fmt.opcode)
            `OP_LUI: begin
                set_reg(ir.u_fmt.rd, {ir.u_fmt.imm, 12'b0});
                pc_m = pc_m + 4;
            end
            `OP_JAL: begin
                set_reg(ir.j_fmt.rd, pc_m + 4);
                pc_m = pc_m + imm_j;
            end
            `OP_BRANCH: begin
                pc_m = branch_taken(ir.b_fmt.funct3, a, b) ? pc_m + imm_b : pc_m + 4;
            end
            `OP_IMM: begin
                set_reg(ir.i_fmt.rd, alu_model(ir.i_fmt.funct3, 1'b0, a, imm_i));
                pc_m = pc_m + 4;
            end
            `OP_REG: begin
                set_reg(ir.r_fmt.rd, alu_model(ir.r_fmt.funct3, ir.r_fmt.funct7[5], a, b));
                pc_m = pc_m + 4;
            end
            `OP_LOAD: begin
                pending    = 1'b1;
                pend_store = 1'b0;
                pend_byte  = (ir.i_fmt.funct3 == 3'b100);
                pend_addr  = a + imm_i;
                pend_rd    = ir.i_fmt.rd;
            end
            `OP_STORE: begin
                pending    = 1'b1;
                pend_store = 1'b1;
                pend_byte  = (ir.s_fmt.funct3 == 3'b000);
                pend_addr  = a + imm_s;
                pend_data  = b;
            end
            default: begin
                pc_m = pc_m + 4;
            end
        endcase
    endtask

    task automatic finish_mem();
        logic [1:0] exp_size;
        exp_size = pend_byte ? `SIZE_BYTE : `SIZE_WORD;
        if (mem_addr !== pend_addr) begin
            flag_mismatch("mem_addr", mem_addr, pend_addr);
        end
        if (mem_size !== exp_size) begin
            flag_mismatch("mem_size", {30'b0, mem_size}, {30'b0, exp_size});
        end
        if (mem_req !== pend_store) begin
            flag_mismatch("mem_req", {31'b0, mem_req}, {31'b0, pend_store});
        end
        if (pend_store) begin
            if (pend_byte && mem_data_write[7:0] !== pend_data[7:0]) begin
                flag_mismatch("sb data", {24'b0, mem_data_write[7:0]}, {24'b0, pend_data[7:0]});
            end
            if (!pend_byte && mem_data_write !== pend_data) begin
                flag_mismatch("sw data", mem_data_write, pend_data);
            end
        end else begin
            set_reg(pend_rd, pend_byte ? {24'b0, mem_data_read[7:0]} : mem_data_read);
        end
        pc_m    = pc_m + 4;
        pending = 1'b0;
    endtask

    always @(posedge inst_selfdefine) begin
        if (reset) begin
            pc_m    = `RESET_PC;
            pending = 1'b0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs_m[i] = '0;
            end
        end else begin
            if (if_valid && if_ready) begin
                if (pending) begin
                    errors++;
                    $display("a fetch completed while a load or store was still outstanding");
                end
                if (if_addr !== pc_m) begin
                    flag_mismatch("fetch address", if_addr, pc_m);
                end
                step_model(if_data_read);
            end
            if (mem_valid && mem_ready) begin
                finish_mem();
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module tb_top;

    localparam int NUM_INSTR  = 400;
    localparam int WAIT_LIMIT = 64;

    logic             inst_selfdefine = 1'b0;
    logic             reset;
    logic             if_ready;
    logic [`XLEN-1:0] if_data_read;
    logic             mem_ready;
    logic [`XLEN-1:0] mem_data_read;
    wire              if_valid;
    wire [`XLEN-1:0]  if_addr;
    wire              mem_valid;
    wire [`XLEN-1:0]  mem_addr;
    wire [`XLEN-1:0]  mem_data_write;
    wire [1:0]        mem_size;
    wire              mem_req;
    wire [31:0]       check_errors;
    int               timeouts;
    logic [31:0]      lfsr;

    always #20 inst_selfdefine = ~inst_selfdefine;

    core_top dut0 (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .if_ready        (if_ready),
        .if_data_read    (if_data_read),
        .if_valid        (if_valid),
        .if_addr         (if_addr),
        .mem_valid       (mem_valid),
        .mem_ready       (mem_ready),
        .mem_data_read   (mem_data_read),
        .mem_addr        (mem_addr),
        .mem_data_write  (mem_data_write),
        .mem_size        (mem_size),
        .mem_req         (mem_req)
    );

    core_checker chk0 (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .if_valid        (if_valid),
        .if_ready        (if_ready),
        .if_data_read    (if_data_read),
        .if_addr         (if_addr),
        .mem_valid       (mem_valid),
        .mem_ready       (mem_ready),
        .mem_data_read   (mem_data_read),
        .mem_addr        (mem_addr),
        .mem_data_write  (mem_data_write),
        .mem_size        (mem_size),
        .mem_req         (mem_req),
        .error_count     (check_errors)
    );

    // galois lfsr, taps 32 31 29 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    task automatic draw(input int nbits, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // registers limited to x0..x7 so x0 and reuse come up often
    task automatic make_instr(output logic [31:0] word, output bit mem_op);
        logic [31:0] sel;
        logic [31:0] r;
        logic [31:0] imm;
        logic [31:0] big;
        logic [31:0] f;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] aimm;
        logic [20:0] joff;
        logic [12:0] boff;
        draw(4, sel);
        draw(9, r);
        draw(12, imm);
        draw(20, big);
        draw(2, f);
        rd   = {2'b00, r[2:0]};
        rs1  = {2'b00, r[5:3]};
        rs2  = {2'b00, r[8:6]};
        aimm = {1'b0, big[8:0], 2'b00};
        joff = {{14{big[4]}}, big[4:0], 2'b00};
        boff = {{6{big[4]}}, big[4:0], 2'b00};
        case (f[1:0])
            2'd0:    f3 = 3'b010;
            2'd1:    f3 = 3'b100;
            2'd2:    f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        mem_op = (sel >= 10 && sel <= 14);
        case (sel)
            0:  word = {big[19:0], rd, `OP_LUI};
            1:  word = {joff[20], joff[10:1], joff[11], joff[19:12], rd, `OP_JAL};
            2, 3, 4, 5: begin
                f3   = (sel == 2) ? 3'b000 : (sel == 3) ? 3'b001 : (sel == 4) ? 3'b100 : 3'b101;
                word = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], `OP_BRANCH};
            end
            7:  word = {imm[11:0], rs1, f3, rd, `OP_IMM};
            8:  word = {1'b0, f[0], 5'b0, rs2, rs1, 3'b000, rd, `OP_REG};
            9:  word = {7'b0, rs2, rs1, f3, rd, `OP_REG};
            10: word = {aimm, 5'd0, 3'b010, rd, `OP_LOAD};
            11: word = {aimm, 5'd0, 3'b100, rd, `OP_LOAD};
            12, 14: word = {aimm[11:5], rs2, 5'd0, 3'b010, aimm[4:0], `OP_STORE};
            13: word = {aimm[11:5], rs2, 5'd0, 3'b000, aimm[4:0], `OP_STORE};
            default: word = {imm[11:0], rs1, 3'b000, rd, `OP_IMM};
        endcase
    endtask

    task automatic wait_fetch(output bit ok);
        ok = 1'b0;
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            @(negedge inst_selfdefine);
            if (if_valid) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            timeouts++;
            $display("timeout: the core raised no fetch request within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic wait_mem(output bit ok);
        ok = 1'b0;
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            @(negedge inst_selfdefine);
            if (mem_valid) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            timeouts++;
            $display("timeout: the core raised no data request within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic serve_fetch(output bit mem_op);
        logic [31:0] delay;
        logic [31:0] word;
        draw(2, delay);
        repeat (delay) @(negedge inst_selfdefine);
        make_instr(word, mem_op);
        if_data_read = word;
        if_ready     = 1'b1;
        @(negedge inst_selfdefine);
        if_ready     = 1'b0;
    endtask

    task automatic serve_mem();
        logic [31:0] delay;
        logic [31:0] data;
        draw(2, delay);
        repeat (delay) @(negedge inst_selfdefine);
        draw(32, data);
        mem_data_read = data;
        mem_ready     = 1'b1;
        @(negedge inst_selfdefine);
        mem_ready     = 1'b0;
    endtask

    initial begin
        bit ok;
        bit mem_op;
        int done;
        int prop_fails;
        reset         = 1'b1;
        if_ready      = 1'b0;
        if_data_read  = '0;
        mem_ready     = 1'b0;
        mem_data_read = '0;
        lfsr          = 32'd73001;
        timeouts      = 0;
        ok            = 1'b1;
        done          = 0;
        repeat (8) @(negedge inst_selfdefine);
        reset = 1'b0;
        while (ok && done < NUM_INSTR) begin
            wait_fetch(ok);
            if (ok) begin
                serve_fetch(mem_op);
                if (mem_op) begin
                    wait_mem(ok);
                    if (ok) begin
                        serve_mem();
                    end
                end
                done++;
            end
        end
        // the next fetch request means the last instruction retired
        if (ok) begin
            wait_fetch(ok);
        end
        prop_fails = dut0.props0.fail_count;
        $display("errors: %0d mismatches, %0d assertion failures, %0d timeouts",
                 check_errors, prop_fails, timeouts);
        if (check_errors == 0 && prop_fails == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
src/core_pkg.sv
src/dec_if.sv
src/core_ctrl.sv
src/pc_unit.sv
src/reg_file.sv
src/alu_unit.sv
src/lsu.sv
src/core_top.sv
tb/core_props.sv
tb/core_checker.sv
tb/tb_top.sv
